/* as2650.f */
+incdir+logic
logic/as2650_pkg.sv
logic/as2650_reg_if.sv
logic/as2650_regfile.sv
logic/as2650_alu.sv
logic/as2650_status.sv
logic/as2650_control.sv
logic/as2650.sv
tb/as2650_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = as2650_tb
RTL_TOP = as2650
FILELIST = as2650.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/as2650_tb.sv */
`default_nettype none

module as2650_tb;

	logic clk, reset, sense;
	logic [7:0] dbus_in, dbus_out;
	logic [12:0] adr;
	logic oeb, rw, opreq, wrp, m_io, d_c, flag;

	logic [31:0] rng;
	logic [7:0] mem [0:511];
	logic [7:0] io_val [0:511]; // Read data per I/O opcode address
	logic is_op [0:511];
	logic [7:0] m_r0, m_psl, m_psu;
	logic [7:0] m_rb [0:1][1:3];
	logic [8:0] exp_wr [$]; // {d_c, data}
	logic [7:0] pending;
	logic [12:0] exp_adr;
	logic spsu_due, halted;
	int wp, cur, errors, checks, tests, bad_tests, wr_wait, mark;

	as2650 UUT (.clk(clk), .reset(reset), .dbus_in(dbus_in), .sense(sense), .adr(adr),
		.dbus_out(dbus_out), .oeb(oeb), .rw(rw), .opreq(opreq), .wrp(wrp), .m_io(m_io),
		.d_c(d_c), .flag(flag));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic logic [1:0] cc_of(input logic [7:0] v);
		return v[7] ? 2'd2 : ((v != 8'd0) ? 2'd1 : 2'd0);
	endfunction

	function logic [7:0] get_reg(input logic [1:0] r);
		return (r == 2'd0) ? m_r0 : m_rb[m_psl[4]][r];
	endfunction

	task set_reg(input logic [1:0] r, input logic [7:0] v);
		if (r == 2'd0) m_r0 = v;
		else m_rb[m_psl[4]][r] = v; // Current bank only
	endtask

	task check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task finish_test(input string name);
		tests++;
		if (errors != mark) bad_tests++;
		$display("test %s: %s (%0d errors)", name, (errors == mark) ? "ok" : "bad", errors - mark);
		mark = errors;
	endtask

	// Reference ALU, updates cc and arithmetic flags in the model psl
	task model_alu(input logic [2:0] grp, input logic [7:0] a, input logic [7:0] b,
		output logic [7:0] res);
		logic cin;
		logic [7:0] bb;
		logic [8:0] s;
		logic [4:0] lo;
		bb = (grp == 3'd5) ? ~b : b;
		cin = m_psl[3] ? m_psl[0] : (grp == 3'd5);
		s = {1'b0, a} + {1'b0, bb} + {8'd0, cin};
		lo = {1'b0, a[3:0]} + {1'b0, bb[3:0]} + {4'd0, cin};
		case (grp)
			3'd0: res = b;
			3'd1: res = a ^ b;
			3'd2: res = a & b;
			3'd3: res = a | b;
			3'd4, 3'd5: res = s[7:0];
			default: res = a;
		endcase
		if (grp == 3'd7) begin
			if (m_psl[1]) m_psl[7:6] = (a > b) ? 2'd1 : ((a < b) ? 2'd2 : 2'd0);
			else m_psl[7:6] = ($signed(a) > $signed(b)) ? 2'd1 :
				(($signed(a) < $signed(b)) ? 2'd2 : 2'd0);
		end else begin
			m_psl[7:6] = cc_of(res);
		end
		if (grp == 3'd4 || grp == 3'd5) begin
			m_psl[0] = s[8];
			m_psl[5] = lo[4];
			m_psl[2] = ((grp == 3'd4) ? (a[7] == b[7]) : (a[7] != b[7])) && (s[7] != a[7]);
		end
	endtask

	task run_op(input int addr);
		logic [7:0] op, imm, v;
		logic [1:0] r;
		logic [2:0] grp;
		op = mem[addr];
		imm = mem[addr + 1];
		r = op[1:0];
		grp = op[7:5];
		if (op == 8'h40) begin
			halted = 1'b1;
		end else if (op == 8'hc0) begin
		end else if (!op[4] && op[3:2] == 2'd0) begin
			model_alu(grp, m_r0, get_reg(r), v);
			if (grp == 3'd6) set_reg(r, v); // strz copies r0 out
			else if (grp != 3'd7) m_r0 = v;
		end else if (!op[4] && op[3:2] == 2'd1 && grp != 3'd6) begin
			model_alu(grp, get_reg(r), imm, v);
			if (grp != 3'd7) set_reg(r, v);
		end else if (op == 8'h13) begin
			v = m_psl;
			m_r0 = v;
			m_psl[7:6] = cc_of(v);
		end else if (op == 8'h12) begin
			spsu_due = 1'b1; // Needs the sense bit of the decode cycle
		end else if (op[7:2] == 6'b011101) begin
			if (op[0]) m_psl = op[1] ? (m_psl | imm) : (m_psl & ~imm);
			else m_psu = op[1] ? (m_psu | imm) : (m_psu & ~imm);
		end else if ((op & 8'hbc) == 8'h30) begin
			set_reg(r, io_val[addr]);
			m_psl[7:6] = cc_of(io_val[addr]);
		end else if ((op & 8'hbc) == 8'hb0) begin
			exp_wr.push_back({op[6], get_reg(r)});
		end
	endtask

	task put(input logic [7:0] b, input logic op_flag);
		mem[wp] = b;
		is_op[wp] = op_flag;
		wp++;
	endtask

	// All registers and both status bytes out on the write port
	task dump_state();
		for (int i = 0; i < 4; i++) put(8'hf0 | 8'(i), 1'b1);
		put(8'h13, 1'b1);
		put(8'hb0, 1'b1);
		put(8'h12, 1'b1);
		put(8'hb0, 1'b1);
	endtask

	task build_program();
		logic [31:0] t, u;
		logic [2:0] g;
		logic [1:0] r;
		for (int i = 0; i < 512; i++) begin
			mem[i] = 8'(i) ^ 8'(i >> 8);
			is_op[i] = 1'b0;
			io_val[i] = 8'd0;
		end
		wp = 0;
		for (int n = 0; n < 60; n++) begin
			if (n % 10 == 9) dump_state();
			t = next_rand();
			u = next_rand();
			g = t[12:10];
			r = t[9:8];
			if (t % 10 < 4) begin
				put(({g, 3'b000, r} == 8'h40) ? 8'hc0 : {g, 3'b000, r}, 1'b1);
			end else if (t % 10 < 7) begin
				put({(g == 3'd6) ? 3'd0 : g, 3'b001, r}, 1'b1);
				put(u[7:0], 1'b0);
			end else if (t % 10 == 7) begin
				put(8'h74 | {6'd0, t[14:13]}, 1'b1);
				put(u[7:0], 1'b0);
			end else if (t % 10 == 8) begin
				io_val[wp] = u[7:0];
				put((t[15] ? 8'h70 : 8'h30) | {6'd0, r}, 1'b1);
			end else begin
				case (t[15:14])
					2'd0: put(8'h12, 1'b1);
					2'd1: put(8'h13, 1'b1);
					2'd2: put(8'hb0 | {6'd0, r}, 1'b1);
					default: put(8'hf0 | {6'd0, r}, 1'b1);
				endcase
			end
		end
		dump_state();
		put(8'h40, 1'b1);
	endtask

	// One cycle of memory, I/O and write-port service, run on the falling edge
	task bus_cycle();
		logic [31:0] t;
		logic [7:0] v;
		t = next_rand();
		sense = t[0];
		if (spsu_due) begin
			v = {sense, m_psu[6:0]};
			m_r0 = v;
			m_psl[7:6] = cc_of(v);
			spsu_due = 1'b0;
		end
		dbus_in = pending;
		pending = 8'd0;
		if (opreq && !rw && m_io) begin
			check_value("adr", adr, exp_adr);
			if (is_op[adr[8:0]]) begin
				check_value("flag", flag, m_psu[6]);
				cur = adr[8:0];
				run_op(cur);
			end
			exp_adr = exp_adr + 13'd1;
			pending = mem[adr[8:0]];
		end else if (opreq && !rw && !m_io) begin
			check_value("d_c", d_c, mem[cur][6]);
			pending = io_val[cur];
		end
		if (wrp) begin
			checks++;
			assert (exp_wr.size() != 0) else begin
				$display("unexpected write strobe at t=%0t", $time);
				errors++;
			end
			if (exp_wr.size() != 0) begin
				check_value("dbus_out", {d_c, dbus_out}, exp_wr.pop_front());
			end
			wr_wait = 0;
		end else if (exp_wr.size() != 0) begin
			wr_wait++;
		end
	endtask

	initial begin
		reset = 1'b1;
		sense = 1'b0;
		dbus_in = 8'd0;
		rng = 32'hff54;
		m_r0 = 8'd0;
		m_psl = 8'd0;
		m_psu = 8'd0;
		for (int b = 0; b < 2; b++) for (int i = 1; i < 4; i++) m_rb[b][i] = 8'd0;
		{errors, checks, tests, bad_tests, wr_wait, mark, cur} = '0;
		{spsu_due, halted} = '0;
		pending = 8'd0;
		exp_adr = 13'd0;
		build_program();
		repeat (2) @(negedge clk);
		check_value("opreq", opreq, 1'b0);
		check_value("rw", rw, 1'b0);
		check_value("wrp", wrp, 1'b0);
		check_value("d_c", d_c, 1'b0);
		check_value("m_io", m_io, 1'b1);
		check_value("oeb", oeb, 1'b1);
		check_value("flag", flag, 1'b0);
		check_value("adr", adr, 13'd0);
		finish_test("reset");
		reset = 1'b0;
		// First fetch request rises as soon as reset drops
		for (int w = 0; !opreq; w++) begin
			if (w > 1) begin
				$display("timeout waiting for first fetch");
				$display("tests failed");
				$finish;
			end
			@(opreq or negedge clk);
		end
		for (int c = 0; !halted; c++) begin
			bus_cycle();
			if (wr_wait > 20 || c > 20000) begin
				$display("%s", (wr_wait > 20) ? "timeout waiting for write" :
					"timeout waiting for halt");
				$display("tests failed");
				$finish;
			end
			@(negedge clk);
		end
		check_value("pending writes", 9'(exp_wr.size()), 9'd0);
		finish_test("program");
		repeat (2) begin
			bus_cycle();
			@(negedge clk);
		end
		repeat (50) begin
			@(negedge clk);
			check_value("opreq", opreq, 1'b0);
		end
		finish_test("halt");
		$display("checks %0d, errors %0d, tests %0d, failing tests %0d",
			checks, errors, tests, bad_tests);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* logic/as2650.sv */
`default_nettype none

`include "as2650_macros.svh"

module as2650 (
	input logic clk,
	input logic reset,
	input logic [`AS2650_DATA_W-1:0] dbus_in,
	input logic sense,
	output logic [`AS2650_ADDR_W-1:0] adr,
	output logic [`AS2650_DATA_W-1:0] dbus_out,
	output logic oeb,
	output logic rw,
	output logic opreq,
	output logic wrp,
	output logic m_io,
	output logic d_c,
	output logic flag
);

	logic [`AS2650_DATA_W-1:0] alu_a, alu_b, alu_result;
	logic [`AS2650_DATA_W-1:0] psu, psl, status_mask;
	as2650_pkg::op_group_e alu_group;
	as2650_pkg::cc_e alu_cc;
	logic alu_carry, alu_ovf, alu_idc;
	logic set_bits, clr_bits, load_arith, load_cc, psl_sel;

	as2650_reg_if reg_bus ();

	assign oeb = !rw; // Memory drives the bus on reads
	assign flag = psu[as2650_pkg::psu_flag];

	as2650_control u_control (
		.clk(clk), .reset(reset), .dbus_in(dbus_in), .alu_result(alu_result),
		.psu(psu), .psl(psl), .alu_a(alu_a), .alu_b(alu_b), .alu_group(alu_group),
		.adr(adr), .dbus_out(dbus_out), .rw(rw), .opreq(opreq), .wrp(wrp), .m_io(m_io),
		.d_c(d_c), .set_bits(set_bits), .clr_bits(clr_bits), .load_arith(load_arith),
		.load_cc(load_cc), .status_mask(status_mask), .psl_sel(psl_sel), .rif(reg_bus.seq)
	);

	as2650_regfile u_regfile (
		.clk(clk), .reset(reset), .bank(psl[as2650_pkg::psl_rs]), .rif(reg_bus.rf)
	);

	as2650_alu u_alu (
		.a(alu_a), .b(alu_b), .group(alu_group), .carry_in(psl[as2650_pkg::psl_c]),
		.with_carry(psl[as2650_pkg::psl_wc]), .logical(psl[as2650_pkg::psl_com]),
		.result(alu_result), .cc(alu_cc), .carry(alu_carry), .ovf(alu_ovf), .idc(alu_idc)
	);

	as2650_status u_status (
		.clk(clk), .reset(reset), .sense(sense), .set_bits(set_bits), .clr_bits(clr_bits),
		.load_arith(load_arith), .load_cc(load_cc), .psl_sel(psl_sel), .mask(status_mask),
		.cc(alu_cc), .carry(alu_carry), .ovf(alu_ovf), .idc(alu_idc), .psu(psu), .psl(psl)
	);

endmodule

`default_nettype wire

/* logic/as2650_control.sv */
`default_nettype none

`include "as2650_macros.svh"

module as2650_control (
	input logic clk,
	input logic reset,
	input logic [`AS2650_DATA_W-1:0] dbus_in,
	input logic [`AS2650_DATA_W-1:0] alu_result,
	input logic [`AS2650_DATA_W-1:0] psu,
	input logic [`AS2650_DATA_W-1:0] psl,
	output logic [`AS2650_DATA_W-1:0] alu_a,
	output logic [`AS2650_DATA_W-1:0] alu_b,
	output as2650_pkg::op_group_e alu_group,
	output logic [`AS2650_ADDR_W-1:0] adr,
	output logic [`AS2650_DATA_W-1:0] dbus_out,
	output logic rw,
	output logic opreq,
	output logic wrp,
	output logic m_io,
	output logic d_c,
	output logic set_bits,
	output logic clr_bits,
	output logic load_arith,
	output logic load_cc,
	output logic [`AS2650_DATA_W-1:0] status_mask,
	output logic psl_sel,
	as2650_reg_if.seq rif
);

	as2650_pkg::state_e state;
	as2650_pkg::op_group_e group;
	logic [`AS2650_PC_W-1:0] pc;
	logic [`AS2650_DATA_W-1:0] ir;
	logic [`AS2650_DATA_W-1:0] holding; // Named register, then immediate
	logic is_alu, alu_z, alu_i, is_sps, is_ps_imm, is_io_rd, is_io_wr, arith;

	assign group = as2650_pkg::op_group_e'(ir[7:5]);
	assign is_alu = !ir[4] && ir != as2650_pkg::op_halt && ir != as2650_pkg::op_nop;
	assign alu_z = is_alu && ir[3:2] == 2'd0;
	assign alu_i = is_alu && ir[3:2] == 2'd1 && group != as2650_pkg::grp_store;
	assign is_sps = ir == as2650_pkg::op_spsu || ir == as2650_pkg::op_spsl;
	assign is_ps_imm = ir == as2650_pkg::op_cpsu || ir == as2650_pkg::op_cpsl ||
		ir == as2650_pkg::op_ppsu || ir == as2650_pkg::op_ppsl;
	assign is_io_rd = {ir[7:2], 2'b00} == as2650_pkg::op_redc ||
		{ir[7:2], 2'b00} == as2650_pkg::op_redd;
	assign is_io_wr = {ir[7:2], 2'b00} == as2650_pkg::op_wrtc ||
		{ir[7:2], 2'b00} == as2650_pkg::op_wrtd;
	assign arith = group == as2650_pkg::grp_add || group == as2650_pkg::grp_sub;

	assign adr = pc[`AS2650_ADDR_W-1:0];
	assign dbus_out = holding;
	assign status_mask = holding;
	assign psl_sel = ir[0]; // Odd opcodes target the lower byte

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= as2650_pkg::st_fetch;
			pc <= '0;
		end else begin
			case (state)
				as2650_pkg::st_fetch: begin
					pc <= pc + 1'b1;
					state <= as2650_pkg::st_decode;
				end
				as2650_pkg::st_decode: state <= as2650_pkg::st_execute;
				as2650_pkg::st_execute: begin
					if (ir == as2650_pkg::op_halt) begin
						state <= as2650_pkg::st_halted;
					end else if (alu_i || is_ps_imm) begin
						pc <= pc + 1'b1; // Skip over the immediate
						state <= as2650_pkg::st_operand;
					end else if (is_io_wr) begin
						state <= as2650_pkg::st_io_strobe;
					end else if (is_io_rd) begin
						state <= as2650_pkg::st_io_done;
					end else begin
						state <= as2650_pkg::st_fetch;
					end
				end
				as2650_pkg::st_operand: state <= as2650_pkg::st_alu;
				as2650_pkg::st_io_strobe: state <= as2650_pkg::st_io_done;
				as2650_pkg::st_halted: state <= as2650_pkg::st_halted; // Until reset
				default: state <= as2650_pkg::st_fetch;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == as2650_pkg::st_decode) begin
			ir <= dbus_in;
			holding <= rif.rdata; // Register named by the incoming opcode
		end else if (state == as2650_pkg::st_operand) begin
			holding <= dbus_in;
		end
	end

	always_comb begin
		opreq = 1'b0;
		rw = 1'b0;
		wrp = 1'b0;
		m_io = 1'b1;
		d_c = 1'b0;
		alu_a = rif.rdata;
		alu_b = holding;
		alu_group = group;
		rif.sel = ir[1:0];
		rif.wdata = alu_result;
		rif.we = 1'b0;
		set_bits = 1'b0;
		clr_bits = 1'b0;
		load_arith = 1'b0;
		load_cc = 1'b0;
		case (state)
			as2650_pkg::st_fetch: opreq = !reset; // Bus stays quiet while reset is held
			as2650_pkg::st_decode: rif.sel = dbus_in[1:0];
			as2650_pkg::st_execute: begin
				if (alu_z) begin
					alu_a = rif.r0;
					// Store writes the named register, the rest write r0
					rif.sel = (group == as2650_pkg::grp_store) ? ir[1:0] : 2'd0;
					rif.we = group != as2650_pkg::grp_com;
					load_arith = arith;
					load_cc = !arith;
				end else if (is_sps) begin
					alu_group = as2650_pkg::grp_load;
					alu_b = ir[0] ? psl : psu;
					rif.sel = 2'd0;
					rif.we = 1'b1;
					load_cc = 1'b1;
				end else if (alu_i || is_ps_imm) begin
					opreq = 1'b1; // Operand read
				end else if (is_io_rd || is_io_wr) begin
					opreq = 1'b1;
					rw = is_io_wr;
					m_io = 1'b0;
					d_c = ir[6];
				end
			end
			as2650_pkg::st_alu: begin
				if (is_ps_imm) begin
					set_bits = ir[1]; // ppsu and ppsl
					clr_bits = !ir[1];
				end else begin
					rif.we = group != as2650_pkg::grp_com;
					load_arith = arith;
					load_cc = !arith;
				end
			end
			as2650_pkg::st_io_strobe: begin
				opreq = 1'b1;
				rw = 1'b1;
				m_io = 1'b0;
				d_c = ir[6];
				wrp = 1'b1;
			end
			as2650_pkg::st_io_done: begin
				if (is_io_rd) begin // Bus released, data arrives now
					alu_group = as2650_pkg::grp_load;
					alu_b = dbus_in;
					rif.we = 1'b1;
					load_cc = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* logic/as2650_status.sv */
`default_nettype none

`include "as2650_macros.svh"

module as2650_status (
	input logic clk,
	input logic reset,
	input logic sense,
	input logic set_bits,
	input logic clr_bits,
	input logic load_arith,
	input logic load_cc,
	input logic psl_sel,
	input logic [`AS2650_DATA_W-1:0] mask,
	input as2650_pkg::cc_e cc,
	input logic carry,
	input logic ovf,
	input logic idc,
	output logic [`AS2650_DATA_W-1:0] psu,
	output logic [`AS2650_DATA_W-1:0] psl
);

	always_ff @(posedge clk) begin
		if (reset) begin
			psu <= '0;
			psl <= '0;
		end else begin
			if (set_bits && psl_sel) psl <= psl | mask;
			if (clr_bits && psl_sel) psl <= psl & ~mask;
			if (set_bits && !psl_sel) psu <= psu | mask;
			if (clr_bits && !psl_sel) psu <= psu & ~mask;

			if (load_cc || load_arith) begin
				psl[as2650_pkg::psl_cc_hi:as2650_pkg::psl_cc_lo] <= cc;
			end
			if (load_arith) begin // Add and subtract only
				psl[as2650_pkg::psl_idc] <= idc;
				psl[as2650_pkg::psl_ovf] <= ovf;
				psl[as2650_pkg::psl_c] <= carry;
			end

			psu[as2650_pkg::psu_sense] <= sense; // Overrides any preset or clear
		end
	end

endmodule

`default_nettype wire

/* logic/as2650_alu.sv */
`default_nettype none

`include "as2650_macros.svh"

module as2650_alu (
	input logic [`AS2650_DATA_W-1:0] a,
	input logic [`AS2650_DATA_W-1:0] b,
	input as2650_pkg::op_group_e group,
	input logic carry_in,
	input logic with_carry,
	input logic logical,
	output logic [`AS2650_DATA_W-1:0] result,
	output as2650_pkg::cc_e cc,
	output logic carry,
	output logic ovf,
	output logic idc
);

	logic is_sub;
	logic cin;
	logic [7:0] b_eff;
	logic [4:0] lo_sum;
	logic [4:0] hi_sum;
	logic [7:0] sum;
	logic a_gt_b;
	logic a_lt_b;

	assign is_sub = group == as2650_pkg::grp_sub;
	assign b_eff = is_sub ? ~b : b; // Subtract as a + ~b + 1
	assign cin = with_carry ? carry_in : is_sub;

	// Split at the nibble to pick up the inter-digit carry
	assign lo_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'd0, cin};
	assign hi_sum = {1'b0, a[7:4]} + {1'b0, b_eff[7:4]} + {4'd0, lo_sum[4]};
	assign sum = {hi_sum[3:0], lo_sum[3:0]};
	assign idc = lo_sum[4];
	assign carry = hi_sum[4]; // No borrow on subtract
	assign ovf = (a[7] == b_eff[7]) && (sum[7] != a[7]);

	assign a_gt_b = logical ? (a > b) : ($signed(a) > $signed(b));
	assign a_lt_b = logical ? (a < b) : ($signed(a) < $signed(b));

	always_comb begin
		case (group)
			as2650_pkg::grp_load: result = b;
			as2650_pkg::grp_eor:  result = a ^ b;
			as2650_pkg::grp_and:  result = a & b;
			as2650_pkg::grp_ior:  result = a | b;
			as2650_pkg::grp_add,
			as2650_pkg::grp_sub:  result = sum;
			default:              result = a; // Store moves a, compare leaves it
		endcase

		if (group == as2650_pkg::grp_com) begin
			cc = a_gt_b ? as2650_pkg::cc_pos : (a_lt_b ? as2650_pkg::cc_neg : as2650_pkg::cc_zero);
		end else if (result[7]) begin
			cc = as2650_pkg::cc_neg;
		end else begin
			cc = (result != '0) ? as2650_pkg::cc_pos : as2650_pkg::cc_zero;
		end
	end

endmodule

`default_nettype wire

/* logic/as2650_regfile.sv */
`default_nettype none

`include "as2650_macros.svh"

module as2650_regfile (
	input logic clk,
	input logic reset,
	input logic bank,
	as2650_reg_if.rf rif
);

	logic [`AS2650_DATA_W-1:0] r0;
	logic [`AS2650_DATA_W-1:0] rb [0:1][1:`AS2650_BANK_REGS];

	assign rif.r0 = r0;

	// r0 is shared by both banks
	assign rif.rdata = (rif.sel == 2'd0) ? r0 : rb[bank][rif.sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
			for (int bk = 0; bk < 2; bk++) begin
				for (int i = 1; i <= `AS2650_BANK_REGS; i++) begin
					rb[bk][i] <= '0;
				end
			end
		end else if (rif.we) begin
			if (rif.sel == 2'd0) begin
				r0 <= rif.wdata;
			end else begin
				rb[bank][rif.sel] <= rif.wdata;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/as2650_reg_if.sv */
`default_nettype none

`include "as2650_macros.svh"

interface as2650_reg_if;
	logic [1:0] sel; // 0 is r0, 1 to 3 are banked
	logic [`AS2650_DATA_W-1:0] rdata;
	logic [`AS2650_DATA_W-1:0] r0;
	logic [`AS2650_DATA_W-1:0] wdata;
	logic we;

	modport seq (
		output sel, wdata, we,
		input rdata, r0
	);

	modport rf (
		input sel, wdata, we,
		output rdata, r0
	);
endinterface

`default_nettype wire

/* logic/as2650_pkg.sv */
`default_nettype none

package as2650_pkg;

	// Opcode bits 7:5
	typedef enum logic [2:0] {
		grp_load,
		grp_eor,
		grp_and,
		grp_ior,
		grp_add,
		grp_sub,
		grp_store,
		grp_com
	} op_group_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_operand,
		st_alu,
		st_io_strobe,
		st_io_done,
		st_halted
	} state_e;

	typedef enum logic [1:0] {
		cc_zero = 2'd0,
		cc_pos  = 2'd1,
		cc_neg  = 2'd2
	} cc_e;

	// Upper status byte
	localparam logic [2:0] psu_sense = 3'd7;
	localparam logic [2:0] psu_flag  = 3'd6;

	// Lower status byte
	localparam logic [2:0] psl_cc_hi = 3'd7;
	localparam logic [2:0] psl_cc_lo = 3'd6;
	localparam logic [2:0] psl_idc   = 3'd5;
	localparam logic [2:0] psl_rs    = 3'd4; // Bank select
	localparam logic [2:0] psl_wc    = 3'd3;
	localparam logic [2:0] psl_ovf   = 3'd2;
	localparam logic [2:0] psl_com   = 3'd1; // Logical compare
	localparam logic [2:0] psl_c     = 3'd0;

	localparam logic [7:0] op_halt = 8'h40; // andz r0
	localparam logic [7:0] op_nop  = 8'hc0; // strz r0
	localparam logic [7:0] op_spsu = 8'h12;
	localparam logic [7:0] op_spsl = 8'h13;
	localparam logic [7:0] op_cpsu = 8'h74;
	localparam logic [7:0] op_cpsl = 8'h75;
	localparam logic [7:0] op_ppsu = 8'h76;
	localparam logic [7:0] op_ppsl = 8'h77;

	// I/O bases, low two bits name the register
	localparam logic [7:0] op_redc = 8'h30;
	localparam logic [7:0] op_redd = 8'h70;
	localparam logic [7:0] op_wrtc = 8'hb0;
	localparam logic [7:0] op_wrtd = 8'hf0;

endpackage

`default_nettype wire

/* logic/as2650_macros.svh */
`ifndef AS2650_MACROS_SVH
`define AS2650_MACROS_SVH

// Data bus and register width
`define AS2650_DATA_W 8

// Only 8K of the 32K space is wired to the pins
`define AS2650_ADDR_W 13

// Full page plus offset
`define AS2650_PC_W 15

// r1 to r3 in each bank
`define AS2650_BANK_REGS 3

`endif
